// File: hdl/motor_pkg.sv
`default_nettype none

package motor_pkg;

	// step counts, positions and stroke
	localparam int STEP_W = 16;
	// period values in ticks
	localparam int SPEED_W = 16;
	// ramp table address, 512 entries
	localparam int RAMP_AW = 9;
	localparam int MS_W = 3;
	localparam int DIV_W = 16;

	// dead time in ticks before a reversed move, at least 2
	localparam int REVERSE_DELAY = 4;
	localparam int REV_CNT_W = $clog2(REVERSE_DELAY);

	// position right after the zero sensor
	localparam logic [STEP_W-1:0] POS_INIT = 1;

	// top bit is busy
	typedef enum logic [1:0] {
		MS_IDLE    = 2'b00,
		MS_PREPARE = 2'b10,
		MS_RUNNING = 2'b11
	} motor_state_t;

endpackage

`default_nettype wire

// File: hdl/regmap_pkg.sv
`default_nettype none

package regmap_pkg;

	localparam int REG_AW = 4;
	localparam int WB_DW = 32;

	// word offsets
	localparam logic [REG_AW-1:0] REG_CTRL     = 4'd0;
	localparam logic [REG_AW-1:0] REG_SPEED    = 4'd1;
	localparam logic [REG_AW-1:0] REG_STEPS    = 4'd2;
	localparam logic [REG_AW-1:0] REG_STROKE   = 4'd3;
	localparam logic [REG_AW-1:0] REG_ACCE_MAX = 4'd4;
	localparam logic [REG_AW-1:0] REG_DEAC_MAX = 4'd5;
	localparam logic [REG_AW-1:0] REG_DIV      = 4'd6;
	localparam logic [REG_AW-1:0] REG_STATUS   = 4'd7;
	localparam logic [REG_AW-1:0] REG_TBL_ACCE = 4'd8;
	localparam logic [REG_AW-1:0] REG_TBL_DEAC = 4'd9;
	localparam logic [REG_AW-1:0] REG_TBL_ADDR = 4'd10;

	// control word
	localparam int CTRL_START  = 0;
	localparam int CTRL_STOP   = 1;
	localparam int CTRL_DIR    = 2;
	localparam int CTRL_XEN    = 3;
	localparam int CTRL_XRST   = 4;
	localparam int CTRL_MS_LSB = 8;

	// status word
	localparam int STAT_BUSY      = 0;
	localparam int STAT_ZP        = 1;
	localparam int STAT_TP        = 2;
	localparam int STAT_SPEED_LSB = 16;

endpackage

`default_nettype wire

// File: hdl/ramp_table.sv
`default_nettype none

module ramp_table
	import motor_pkg::*;
(
	input  wire                clk,
	input  wire                i_we,
	input  wire  [RAMP_AW-1:0] i_waddr,
	input  wire  [SPEED_W-1:0] i_wdata,
	input  wire                i_re,
	input  wire  [RAMP_AW-1:0] i_raddr,
	output logic [SPEED_W-1:0] o_rdata
);

	logic [SPEED_W-1:0] mem [2**RAMP_AW];
	logic [SPEED_W-1:0] rd_q;

	always_ff @(posedge clk) begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// array read, then output register
	always_ff @(posedge clk) begin
		if (i_re)
			rd_q <= mem[i_raddr];
		o_rdata <= rd_q;
	end

endmodule

`default_nettype wire

// File: hdl/step_tick_div.sv
`default_nettype none

module step_tick_div
	import motor_pkg::*;
(
	input  wire              clk,
	input  wire              resetn,
	input  wire  [DIV_W-1:0] i_div,
	output logic             o_tick
);

	logic [DIV_W-1:0] cnt;

	// i_div only taken on reload
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= i_div;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/wb_motor_regs.sv
`default_nettype none

module wb_motor_regs
	import motor_pkg::*, regmap_pkg::*;
(
	input  wire                clk,
	input  wire                resetn,

	input  wire                i_wb_cyc,
	input  wire                i_wb_stb,
	input  wire                i_wb_we,
	input  wire  [REG_AW-1:0]  i_wb_adr,
	input  wire  [WB_DW-1:0]   i_wb_dat,
	output logic [WB_DW-1:0]   o_wb_dat,
	output logic               o_wb_ack,

	output logic               o_pri_start,
	output logic               o_pri_stop,
	output logic [SPEED_W-1:0] o_pri_speed,
	output logic [STEP_W-1:0]  o_pri_steps,
	output logic               o_pri_dir,
	output logic [MS_W-1:0]    o_ms,
	output logic               o_xen,
	output logic               o_xrst,
	output logic [STEP_W-1:0]  o_stroke,
	output logic [RAMP_AW-1:0] o_acce_max,
	output logic [RAMP_AW-1:0] o_deac_max,
	output logic [DIV_W-1:0]   o_div,
	output logic [RAMP_AW-1:0] o_tbl_addr,
	output logic               o_acce_we,
	output logic               o_deac_we,
	output logic [SPEED_W-1:0] o_tbl_data,

	input  wire                i_busy,
	input  wire                i_zpsign,
	input  wire                i_tpsign,
	input  wire  [SPEED_W-1:0] i_rt_speed
);

	logic             accept;
	logic             wr_en;
	logic [WB_DW-1:0] ctrl_word;
	logic [WB_DW-1:0] stat_word;
	logic [WB_DW-1:0] rd_data;

	assign accept = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign wr_en  = accept && i_wb_we;

	always_ff @(posedge clk) begin
		if (!resetn)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= accept;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_pri_start <= 1'b0;
			o_pri_stop  <= 1'b0;
			o_pri_speed <= '0;
			o_pri_steps <= '0;
			o_pri_dir   <= 1'b0;
			o_ms        <= '0;
			o_xen       <= 1'b0;
			o_xrst      <= 1'b0;
			o_stroke    <= '0;
			o_acce_max  <= '0;
			o_deac_max  <= '0;
			o_div       <= '0;
			o_tbl_addr  <= '0;
			o_acce_we   <= 1'b0;
			o_deac_we   <= 1'b0;
		end else begin
			o_pri_start <= 1'b0;
			o_pri_stop  <= 1'b0;
			o_acce_we   <= 1'b0;
			o_deac_we   <= 1'b0;
			// step the address once the table write has gone out
			if (o_acce_we || o_deac_we)
				o_tbl_addr <= o_tbl_addr + 1'b1;
			if (wr_en) begin
				case (i_wb_adr)
				REG_CTRL: begin
					o_pri_start <= i_wb_dat[CTRL_START];
					o_pri_stop  <= i_wb_dat[CTRL_STOP];
					o_pri_dir   <= i_wb_dat[CTRL_DIR];
					o_xen       <= i_wb_dat[CTRL_XEN];
					o_xrst      <= i_wb_dat[CTRL_XRST];
					o_ms        <= i_wb_dat[CTRL_MS_LSB +: MS_W];
				end
				REG_SPEED:    o_pri_speed <= i_wb_dat[SPEED_W-1:0];
				REG_STEPS:    o_pri_steps <= i_wb_dat[STEP_W-1:0];
				REG_STROKE:   o_stroke    <= i_wb_dat[STEP_W-1:0];
				REG_ACCE_MAX: o_acce_max  <= i_wb_dat[RAMP_AW-1:0];
				REG_DEAC_MAX: o_deac_max  <= i_wb_dat[RAMP_AW-1:0];
				REG_DIV:      o_div       <= i_wb_dat[DIV_W-1:0];
				REG_TBL_ACCE: o_acce_we   <= 1'b1;
				REG_TBL_DEAC: o_deac_we   <= 1'b1;
				REG_TBL_ADDR: o_tbl_addr  <= i_wb_dat[RAMP_AW-1:0];
				default: ;
				endcase
			end
		end
	end

	// shared data for both tables
	always_ff @(posedge clk) begin
		if (wr_en && (i_wb_adr == REG_TBL_ACCE || i_wb_adr == REG_TBL_DEAC))
			o_tbl_data <= i_wb_dat[SPEED_W-1:0];
	end

	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_DIR] = o_pri_dir;
		ctrl_word[CTRL_XEN] = o_xen;
		ctrl_word[CTRL_XRST] = o_xrst;
		ctrl_word[CTRL_MS_LSB +: MS_W] = o_ms;

		stat_word = '0;
		stat_word[STAT_BUSY] = i_busy;
		stat_word[STAT_ZP] = i_zpsign;
		stat_word[STAT_TP] = i_tpsign;
		stat_word[STAT_SPEED_LSB +: SPEED_W] = i_rt_speed;
	end

	// table data ports read back as zero
	always_comb begin
		case (i_wb_adr)
		REG_CTRL:     rd_data = ctrl_word;
		REG_SPEED:    rd_data = WB_DW'(o_pri_speed);
		REG_STEPS:    rd_data = WB_DW'(o_pri_steps);
		REG_STROKE:   rd_data = WB_DW'(o_stroke);
		REG_ACCE_MAX: rd_data = WB_DW'(o_acce_max);
		REG_DEAC_MAX: rd_data = WB_DW'(o_deac_max);
		REG_DIV:      rd_data = WB_DW'(o_div);
		REG_STATUS:   rd_data = stat_word;
		REG_TBL_ADDR: rd_data = WB_DW'(o_tbl_addr);
		default:      rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept)
			o_wb_dat <= rd_data;
	end

	// one ack per accepted cycle, so the host never sees a double ack
	ack_single: assert property (@(posedge clk) disable iff (!resetn)
		o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

// File: hdl/step_motor_core.sv
`default_nettype none

module step_motor_core
	import motor_pkg::*;
(
	input  wire                clk,
	input  wire                resetn,
	input  wire                i_tick,

	input  wire  [RAMP_AW-1:0] i_acce_max,
	input  wire  [RAMP_AW-1:0] i_deac_max,

	output logic               o_acce_re,
	output logic [RAMP_AW-1:0] o_acce_addr,
	input  wire  [SPEED_W-1:0] i_acce_data,
	output logic               o_deac_re,
	output logic [RAMP_AW-1:0] o_deac_addr,
	input  wire  [SPEED_W-1:0] i_deac_data,

	input  wire                i_zpd,
	input  wire  [STEP_W-1:0]  i_stroke,
	input  wire  [MS_W-1:0]    i_ms,

	input  wire                i_pri_start,
	input  wire                i_pri_stop,
	input  wire  [SPEED_W-1:0] i_pri_speed,
	input  wire  [STEP_W-1:0]  i_pri_steps,
	input  wire                i_pri_dir,

	input  wire                i_ext_sel,
	input  wire                i_ext_start,
	input  wire                i_ext_stop,
	input  wire  [SPEED_W-1:0] i_ext_speed,
	input  wire  [STEP_W-1:0]  i_ext_steps,
	input  wire                i_ext_dir,

	output logic               o_drive,
	output logic               o_dir,
	output logic [MS_W-1:0]    o_ms,
	output logic               o_busy,
	output logic               o_zpsign,
	output logic               o_tpsign,
	output logic [SPEED_W-1:0] o_rt_speed
);

	motor_state_t state;

	logic                 start_hold;
	logic                 stop_hold;
	logic [SPEED_W-1:0]   req_speed;
	logic [STEP_W-1:0]    req_steps;
	logic                 req_dir;
	logic                 should_start;
	logic                 should_stop;

	logic [SPEED_W-1:0]   speed_max;
	logic [SPEED_W-1:0]   speed_var;
	logic [SPEED_W-1:0]   speed_cnt;
	logic [STEP_W-1:0]    step_cnt;
	logic [STEP_W-1:0]    step_remain;
	logic                 step_done;
	logic                 high_end;
	logic [REV_CNT_W-1:0] rev_cnt;

	logic                 rd_en;
	logic [4:0]           rd_pipe;
	logic                 acce_ing;
	logic                 deac_ing;

	logic                 fwd;
	logic                 drive_d1;
	logic                 drive_fall;
	logic [STEP_W-1:0]    position;
	logic [STEP_W-1:0]    pos_next;

	assign o_busy       = state[1];
	assign fwd          = (o_dir == 1'b0);
	assign should_start = i_tick && start_hold && !o_busy;
	assign high_end     = (speed_cnt == '0) && o_drive;

	// commands only taken while idle, held until a tick consumes them
	always_ff @(posedge clk) begin
		if (!resetn)
			start_hold <= 1'b0;
		else if (start_hold) begin
			if (i_tick)
				start_hold <= 1'b0;
		end else if (!o_busy && (i_ext_sel ? i_ext_start : i_pri_start))
			start_hold <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			stop_hold <= 1'b0;
		else if (stop_hold) begin
			if (i_tick)
				stop_hold <= 1'b0;
		end else if (o_busy && (i_ext_sel ? i_ext_stop : i_pri_stop))
			stop_hold <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!start_hold && !o_busy) begin
			req_speed <= i_ext_sel ? i_ext_speed : i_pri_speed;
			req_steps <= i_ext_sel ? i_ext_steps : i_pri_steps;
			req_dir   <= i_ext_sel ? i_ext_dir : i_pri_dir;
		end
	end

	always_ff @(posedge clk) begin
		if (should_start) begin
			speed_max <= req_speed;
			o_ms      <= i_ms;
		end
	end

	// last direction decides whether the dead time is needed
	always_ff @(posedge clk) begin
		if (!resetn)
			o_dir <= 1'b0;
		else if (should_start)
			o_dir <= req_dir;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= MS_IDLE;
		else if (i_tick) begin
			case (state)
			MS_IDLE: begin
				if (start_hold)
					state <= (o_dir == req_dir) ? MS_RUNNING : MS_PREPARE;
			end
			MS_PREPARE: begin
				if (stop_hold)
					state <= MS_IDLE;
				else if (rev_cnt == REV_CNT_W'(REVERSE_DELAY - 2))
					state <= MS_RUNNING;
			end
			MS_RUNNING: begin
				if (stop_hold || should_stop)
					state <= MS_IDLE;
			end
			default: state <= MS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			rev_cnt <= '0;
		else if (i_tick) begin
			if (state == MS_PREPARE)
				rev_cnt <= rev_cnt + 1'b1;
			else
				rev_cnt <= '0;
		end
	end

	// no read after the final step, so the last rt_speed stays in range
	always_ff @(posedge clk) begin
		if (!resetn)
			rd_en <= 1'b0;
		else if (rd_en)
			rd_en <= 1'b0;
		else if (i_tick)
			rd_en <= (state == MS_IDLE && start_hold)
				|| (state == MS_RUNNING && high_end && step_remain != '0);
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			step_done <= 1'b0;
		else if (i_tick) begin
			if (state != MS_RUNNING)
				step_done <= 1'b0;
			else if (high_end && step_remain == '0)
				step_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt    <= '0;
			step_remain <= '0;
		end else if (i_tick) begin
			if (state == MS_IDLE && start_hold) begin
				step_cnt    <= '0;
				step_remain <= req_steps - 1'b1;
			end else if (state == MS_RUNNING && high_end) begin
				step_cnt    <= step_cnt + 1'b1;
				step_remain <= step_remain - 1'b1;
			end
		end
	end

	// ramp read, six cycles from rd_en to rt_speed
	always_ff @(posedge clk) begin
		if (!resetn)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[3:0], rd_en};
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			acce_ing <= step_cnt < STEP_W'(i_acce_max);
			deac_ing <= step_remain < STEP_W'(i_deac_max);
		end
		if (rd_pipe[0]) begin
			o_acce_addr <= acce_ing ? step_cnt[RAMP_AW-1:0] : i_acce_max;
			o_deac_addr <= deac_ing ? step_remain[RAMP_AW-1:0] : i_deac_max;
		end
		if (rd_pipe[3])
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
		if (rd_pipe[4])
			o_rt_speed <= (speed_var > speed_max) ? speed_var : speed_max;
	end

	assign o_acce_re = rd_pipe[1];
	assign o_deac_re = rd_pipe[1];

	// half-period counter
	always_ff @(posedge clk) begin
		if (!resetn)
			speed_cnt <= '0;
		else if (i_tick) begin
			if (state != MS_RUNNING)
				speed_cnt <= '0;
			else if (speed_cnt == '0)
				speed_cnt <= o_rt_speed;
			else
				speed_cnt <= speed_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_drive <= 1'b0;
		else if (i_tick) begin
			if (state != MS_RUNNING)
				o_drive <= 1'b0;
			else if (speed_cnt == '0 && !step_done)
				o_drive <= !o_drive;
		end
	end

	assign should_stop = (step_done && speed_cnt == '0)
		|| (o_tpsign && fwd)
		|| (o_zpsign && !fwd);

	// zero sign follows the sensor, clears only when moving away
	always_ff @(posedge clk) begin
		if (!resetn)
			o_zpsign <= 1'b0;
		else if (i_zpd)
			o_zpsign <= 1'b1;
		else if (state == MS_RUNNING && fwd)
			o_zpsign <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			drive_d1 <= 1'b0;
		else
			drive_d1 <= o_drive;
	end

	assign drive_fall = drive_d1 && !o_drive;

	always_comb begin
		pos_next = position;
		if (fwd) begin
			if (position != i_stroke)
				pos_next = position + 1'b1;
		end else if (position > POS_INIT)
			pos_next = position - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn || o_zpsign)
			position <= POS_INIT;
		else if (drive_fall)
			position <= pos_next;
	end

	// set on the edge that lands on the stroke
	always_ff @(posedge clk) begin
		if (!resetn)
			o_tpsign <= 1'b0;
		else if (drive_fall)
			o_tpsign <= fwd && (pos_next == i_stroke);
	end

	// dead time must leave the output idle
	prepare_quiet: assert property (@(posedge clk) disable iff (!resetn)
		state == MS_PREPARE |-> !o_drive);

	state_legal: assert property (@(posedge clk) disable iff (!resetn)
		state != 2'b01);

endmodule

`default_nettype wire

// File: hdl/stepper_top.sv
`default_nettype none

module stepper_top
	import motor_pkg::*, regmap_pkg::*;
(
	input  wire                clk,
	input  wire                resetn,

	input  wire                i_wb_cyc,
	input  wire                i_wb_stb,
	input  wire                i_wb_we,
	input  wire  [REG_AW-1:0]  i_wb_adr,
	input  wire  [WB_DW-1:0]   i_wb_dat,
	output logic [WB_DW-1:0]   o_wb_dat,
	output logic               o_wb_ack,

	input  wire                i_ext_sel,
	input  wire                i_ext_start,
	input  wire                i_ext_stop,
	input  wire  [SPEED_W-1:0] i_ext_speed,
	input  wire  [STEP_W-1:0]  i_ext_steps,
	input  wire                i_ext_dir,

	input  wire                i_zpd,

	output logic               o_drive,
	output logic               o_dir,
	output logic [MS_W-1:0]    o_ms,
	output logic               o_xen,
	output logic               o_xrst,

	output logic               o_ext_busy,
	output logic               o_ext_zpsign,
	output logic               o_ext_tpsign,
	output logic [SPEED_W-1:0] o_rt_speed
);

	logic               pri_start;
	logic               pri_stop;
	logic [SPEED_W-1:0] pri_speed;
	logic [STEP_W-1:0]  pri_steps;
	logic               pri_dir;
	logic [MS_W-1:0]    reg_ms;
	logic [STEP_W-1:0]  stroke;
	logic [RAMP_AW-1:0] acce_max;
	logic [RAMP_AW-1:0] deac_max;
	logic [DIV_W-1:0]   div;
	logic               tick;

	logic [RAMP_AW-1:0] tbl_addr;
	logic [SPEED_W-1:0] tbl_data;
	logic               acce_we;
	logic               deac_we;
	logic               acce_re;
	logic               deac_re;
	logic [RAMP_AW-1:0] acce_addr;
	logic [RAMP_AW-1:0] deac_addr;
	logic [SPEED_W-1:0] acce_data;
	logic [SPEED_W-1:0] deac_data;

	wb_motor_regs regs_i (
		.clk         (clk),
		.resetn      (resetn),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_pri_start (pri_start),
		.o_pri_stop  (pri_stop),
		.o_pri_speed (pri_speed),
		.o_pri_steps (pri_steps),
		.o_pri_dir   (pri_dir),
		.o_ms        (reg_ms),
		.o_xen       (o_xen),
		.o_xrst      (o_xrst),
		.o_stroke    (stroke),
		.o_acce_max  (acce_max),
		.o_deac_max  (deac_max),
		.o_div       (div),
		.o_tbl_addr  (tbl_addr),
		.o_acce_we   (acce_we),
		.o_deac_we   (deac_we),
		.o_tbl_data  (tbl_data),
		.i_busy      (o_ext_busy),
		.i_zpsign    (o_ext_zpsign),
		.i_tpsign    (o_ext_tpsign),
		.i_rt_speed  (o_rt_speed)
	);

	step_tick_div div_i (
		.clk    (clk),
		.resetn (resetn),
		.i_div  (div),
		.o_tick (tick)
	);

	ramp_table acce_tbl_i (
		.clk     (clk),
		.i_we    (acce_we),
		.i_waddr (tbl_addr),
		.i_wdata (tbl_data),
		.i_re    (acce_re),
		.i_raddr (acce_addr),
		.o_rdata (acce_data)
	);

	ramp_table deac_tbl_i (
		.clk     (clk),
		.i_we    (deac_we),
		.i_waddr (tbl_addr),
		.i_wdata (tbl_data),
		.i_re    (deac_re),
		.i_raddr (deac_addr),
		.o_rdata (deac_data)
	);

	step_motor_core core_i (
		.clk         (clk),
		.resetn      (resetn),
		.i_tick      (tick),
		.i_acce_max  (acce_max),
		.i_deac_max  (deac_max),
		.o_acce_re   (acce_re),
		.o_acce_addr (acce_addr),
		.i_acce_data (acce_data),
		.o_deac_re   (deac_re),
		.o_deac_addr (deac_addr),
		.i_deac_data (deac_data),
		.i_zpd       (i_zpd),
		.i_stroke    (stroke),
		.i_ms        (reg_ms),
		.i_pri_start (pri_start),
		.i_pri_stop  (pri_stop),
		.i_pri_speed (pri_speed),
		.i_pri_steps (pri_steps),
		.i_pri_dir   (pri_dir),
		.i_ext_sel   (i_ext_sel),
		.i_ext_start (i_ext_start),
		.i_ext_stop  (i_ext_stop),
		.i_ext_speed (i_ext_speed),
		.i_ext_steps (i_ext_steps),
		.i_ext_dir   (i_ext_dir),
		.o_drive     (o_drive),
		.o_dir       (o_dir),
		.o_ms        (o_ms),
		.o_busy      (o_ext_busy),
		.o_zpsign    (o_ext_zpsign),
		.o_tpsign    (o_ext_tpsign),
		.o_rt_speed  (o_rt_speed)
	);

endmodule

`default_nettype wire

// File: tb/stepper_clkgen.sv
`default_nettype none

module stepper_clkgen (
	output logic o_clk,
	output logic o_resetn
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// held low for four rising edges
	initial begin
		o_resetn = 1'b0;
		repeat (4) @(posedge o_clk);
		#1 o_resetn = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/stepper_tb.sv
`default_nettype none

module stepper_tb
	import motor_pkg::*, regmap_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TBL_N = 16;
	localparam int TBL_MAX = TBL_N - 1;
	localparam int MAX_PERIOD = 300;
	// divider of 7, one tick every 8 cycles
	localparam int TICK_CYCLES = 8;
	// 2, 3a, 3b, 4, 5 reverse, 5 forward, 6
	localparam int WORST_STEPS = 20 + 4 + 200 + 100 + 50 + 8;
	localparam int CYCLE_LIMIT = WORST_STEPS * (MAX_PERIOD + 1) * 8 * 2;

	logic               clk;
	logic               resetn;
	logic               i_wb_cyc;
	logic               i_wb_stb;
	logic               i_wb_we;
	logic [REG_AW-1:0]  i_wb_adr;
	logic [WB_DW-1:0]   i_wb_dat;
	logic [WB_DW-1:0]   o_wb_dat;
	logic               o_wb_ack;
	logic               i_ext_sel;
	logic               i_ext_start;
	logic               i_ext_stop;
	logic [SPEED_W-1:0] i_ext_speed;
	logic [STEP_W-1:0]  i_ext_steps;
	logic               i_ext_dir;
	logic               i_zpd;
	logic               o_drive;
	logic               o_dir;
	logic [MS_W-1:0]    o_ms;
	logic               o_xen;
	logic               o_xrst;
	logic               o_ext_busy;
	logic               o_ext_zpsign;
	logic               o_ext_tpsign;
	logic [SPEED_W-1:0] o_rt_speed;

	logic [SPEED_W-1:0] acce_tab [TBL_N];
	logic [SPEED_W-1:0] deac_tab [TBL_N];

	int          seed = 4;
	int          edge_count = 0;
	int          ack_count = 0;
	logic        drive_q = 1'b0;
	int          req_id = 0;
	int          done_id = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	string       cur_name;
	string       note;
	string       name_q [$];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];

	stepper_clkgen clkgen_i (
		.o_clk    (clk),
		.o_resetn (resetn)
	);

	stepper_top dut_i (
		.clk          (clk),
		.resetn       (resetn),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.o_wb_dat     (o_wb_dat),
		.o_wb_ack     (o_wb_ack),
		.i_ext_sel    (i_ext_sel),
		.i_ext_start  (i_ext_start),
		.i_ext_stop   (i_ext_stop),
		.i_ext_speed  (i_ext_speed),
		.i_ext_steps  (i_ext_steps),
		.i_ext_dir    (i_ext_dir),
		.i_zpd        (i_zpd),
		.o_drive      (o_drive),
		.o_dir        (o_dir),
		.o_ms         (o_ms),
		.o_xen        (o_xen),
		.o_xrst       (o_xrst),
		.o_ext_busy   (o_ext_busy),
		.o_ext_zpsign (o_ext_zpsign),
		.o_ext_tpsign (o_ext_tpsign),
		.o_rt_speed   (o_rt_speed)
	);

	// largest of the clamped table entries and the cruise period
	function automatic logic [SPEED_W-1:0] ref_speed(int index, int steps,
		logic [SPEED_W-1:0] cruise);
		int                 ai;
		int                 di;
		logic [SPEED_W-1:0] a;
		logic [SPEED_W-1:0] d;
		logic [SPEED_W-1:0] m;
		ai = (index < TBL_MAX) ? index : TBL_MAX;
		di = steps - 1 - index;
		di = (di < TBL_MAX) ? di : TBL_MAX;
		a = acce_tab[ai[3:0]];
		d = deac_tab[di[3:0]];
		m = (a > d) ? a : d;
		return (m > cruise) ? m : cruise;
	endfunction

	function automatic logic [WB_DW-1:0] ctrl_value(logic start, logic stop, logic dir,
		logic [MS_W-1:0] ms);
		logic [WB_DW-1:0] w;
		w = '0;
		w[CTRL_START] = start;
		w[CTRL_STOP] = stop;
		w[CTRL_DIR] = dir;
		w[CTRL_MS_LSB +: MS_W] = ms;
		return w;
	endfunction

	// edges and acks sampled mid-cycle
	always @(negedge clk) begin
		if (o_drive && !drive_q)
			edge_count <= edge_count + 1;
		drive_q <= o_drive;
		if (o_wb_ack)
			ack_count <= ack_count + 1;
	end

	initial begin
		repeat (CYCLE_LIMIT) @(posedge clk);
		$display("run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic bus_access(input logic we, input logic [REG_AW-1:0] adr,
		input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
		int n;
		n = 0;
		rdat = '0;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		@(posedge clk);
		#1;
		while (!o_wb_ack && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!o_wb_ack)
			note = "a bus access got no ack";
		else
			rdat = o_wb_dat;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		@(posedge clk);
		#1;
		if (o_wb_ack)
			note = "ack stayed high for a second cycle";
	endtask

	task automatic bus_write(input logic [REG_AW-1:0] adr, input logic [WB_DW-1:0] dat);
		logic [WB_DW-1:0] unused;
		bus_access(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input logic [REG_AW-1:0] adr, output logic [WB_DW-1:0] dat);
		bus_access(1'b0, adr, '0, dat);
	endtask

	task automatic wait_busy(input logic level);
		while (o_ext_busy !== level) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic start_move(input int speed, input int steps, input logic dir,
		input logic [MS_W-1:0] ms);
		bus_write(REG_SPEED, WB_DW'(speed));
		bus_write(REG_STEPS, WB_DW'(steps));
		bus_write(REG_CTRL, ctrl_value(1'b1, 1'b0, dir, ms));
		wait_busy(1'b1);
	endtask

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic begin_test(input string name);
		cur_name = name;
		note = "";
		name_q.delete();
		exp_q.delete();
		act_q.delete();
	endtask

	task automatic end_test();
		req_id++;
		wait (done_id == req_id);
	endtask

	// compares the values collected during one test
	initial begin
		string line;
		logic  bad;
		forever begin
			wait (req_id != done_id);
			bad = 1'b0;
			line = "";
			foreach (exp_q[i]) begin
				if (exp_q[i] !== act_q[i] && !bad) begin
					line = $sformatf("[ERROR] %s expected %0d actual %0d",
						name_q[i], exp_q[i], act_q[i]);
					bad = 1'b1;
				end
			end
			if (!bad && note != "") begin
				line = $sformatf("%s failed, %s", cur_name, note);
				bad = 1'b1;
			end
			if (bad) begin
				fail_cnt++;
				$display("%s", line);
			end else begin
				pass_cnt++;
				$display("%s ok", cur_name);
			end
			done_id = req_id;
		end
	end

	initial begin
		logic [WB_DW-1:0] rd;
		int               base;
		int               acks;
		int               rv;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_ext_sel = 1'b0;
		i_ext_start = 1'b0;
		i_ext_stop = 1'b0;
		i_ext_speed = '0;
		i_ext_steps = '0;
		i_ext_dir = 1'b0;
		i_zpd = 1'b0;
		wait (resetn === 1'b1);
		@(posedge clk);
		#1;

		begin_test("reg_access");
		acks = ack_count;
		bus_write(REG_SPEED, 32'd1234);
		bus_write(REG_STEPS, 32'd567);
		bus_write(REG_STROKE, 32'd890);
		bus_write(REG_DIV, 32'd12);
		bus_write(REG_CTRL, (WB_DW'(1) << CTRL_XEN) | (WB_DW'(1) << CTRL_XRST));
		expect_eq("reg_access xen", 32'd1, 32'(o_xen));
		expect_eq("reg_access xrst", 32'd1, 32'(o_xrst));
		bus_read(REG_SPEED, rd);
		expect_eq("reg_access speed", 32'd1234, rd);
		bus_read(REG_STEPS, rd);
		expect_eq("reg_access steps", 32'd567, rd);
		bus_read(REG_STROKE, rd);
		expect_eq("reg_access stroke", 32'd890, rd);
		bus_read(REG_DIV, rd);
		expect_eq("reg_access div", 32'd12, rd);
		expect_eq("reg_access ack count", 32'd9, ack_count - acks);
		end_test();

		begin_test("step_count");
		// ramp tables and move setup
		bus_write(REG_ACCE_MAX, WB_DW'(TBL_MAX));
		bus_write(REG_DEAC_MAX, WB_DW'(TBL_MAX));
		bus_write(REG_TBL_ADDR, '0);
		for (int i = 0; i < TBL_N; i++) begin
			rv = $random(seed);
			acce_tab[i] = SPEED_W'(rv[7:0]) + 16'd4;
			bus_write(REG_TBL_ACCE, WB_DW'(acce_tab[i]));
		end
		bus_write(REG_TBL_ADDR, '0);
		for (int i = 0; i < TBL_N; i++) begin
			rv = $random(seed);
			deac_tab[i] = SPEED_W'(rv[7:0]) + 16'd4;
			bus_write(REG_TBL_DEAC, WB_DW'(deac_tab[i]));
		end
		bus_write(REG_DIV, 32'd7);
		bus_write(REG_STROKE, 32'd1000);

		base = edge_count;
		start_move(10, 20, 1'b0, 3'd5);
		expect_eq("step_count dir", 32'd0, 32'(o_dir));
		expect_eq("step_count ms", 32'd5, 32'(o_ms));
		expect_eq("step_count xen", 32'd0, 32'(o_xen));
		expect_eq("step_count xrst", 32'd0, 32'(o_xrst));
		wait_busy(1'b0);
		repeat (TICK_CYCLES) @(posedge clk);
		#1;
		expect_eq("step_count edges", 32'd20, edge_count - base);
		expect_eq("step_count busy", 32'd0, 32'(o_ext_busy));
		expect_eq("step_count drive", 32'd0, 32'(o_drive));
		end_test();

		begin_test("ramp_speed");
		expect_eq("ramp_speed table", 32'(ref_speed(19, 20, 16'd10)), 32'(o_rt_speed));
		start_move(MAX_PERIOD, 4, 1'b0, 3'd0);
		wait_busy(1'b0);
		expect_eq("ramp_speed cruise", 32'(ref_speed(3, 4, 16'(MAX_PERIOD))),
			32'(o_rt_speed));
		end_test();

		begin_test("stop");
		base = edge_count;
		start_move(10, 200, 1'b0, 3'd0);
		while (edge_count - base < 10) begin
			@(posedge clk);
			#1;
		end
		bus_write(REG_CTRL, ctrl_value(1'b0, 1'b1, 1'b0, 3'd0));
		wait_busy(1'b0);
		// drive is forced low on the first tick after the move ends
		repeat (TICK_CYCLES) @(posedge clk);
		#1;
		if (edge_count - base >= 200)
			note = "the stop request did not cut the move short";
		expect_eq("stop drive", 32'd0, 32'(o_drive));
		end_test();

		begin_test("zero_terminal");
		base = edge_count;
		start_move(10, 100, 1'b1, 3'd0);
		expect_eq("zero_terminal dir", 32'd1, 32'(o_dir));
		while (edge_count - base < 3) begin
			@(posedge clk);
			#1;
		end
		i_zpd = 1'b1;
		wait_busy(1'b0);
		i_zpd = 1'b0;
		// zero sign holds until a forward move
		repeat (TICK_CYCLES) @(posedge clk);
		#1;
		expect_eq("zero_terminal zpsign", 32'd1, 32'(o_ext_zpsign));
		bus_write(REG_STROKE, 32'd6);
		base = edge_count;
		start_move(10, 50, 1'b0, 3'd0);
		wait_busy(1'b0);
		repeat (TICK_CYCLES) @(posedge clk);
		#1;
		expect_eq("zero_terminal edges", 32'd5, edge_count - base);
		expect_eq("zero_terminal tpsign", 32'd1, 32'(o_ext_tpsign));
		end_test();

		begin_test("ext_port");
		i_ext_speed = 16'd10;
		i_ext_steps = 16'd8;
		i_ext_dir = 1'b1;
		i_ext_sel = 1'b1;
		base = edge_count;
		bus_write(REG_STEPS, 32'd8);
		bus_write(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0, 3'd0));
		repeat (200) @(posedge clk);
		#1;
		expect_eq("ext_port bus start edges", 32'd0, edge_count - base);
		expect_eq("ext_port bus start busy", 32'd0, 32'(o_ext_busy));
		i_ext_start = 1'b1;
		@(posedge clk);
		#1;
		i_ext_start = 1'b0;
		wait_busy(1'b1);
		bus_read(REG_STATUS, rd);
		expect_eq("ext_port status busy", 32'd1, 32'(rd[STAT_BUSY]));
		wait_busy(1'b0);
		repeat (TICK_CYCLES) @(posedge clk);
		#1;
		bus_read(REG_STATUS, rd);
		expect_eq("ext_port status idle", 32'd0, 32'(rd[STAT_BUSY]));
		expect_eq("ext_port edges", 32'd8, edge_count - base);
		end_test();

		$display("passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: stepper.f
hdl/motor_pkg.sv
hdl/regmap_pkg.sv
hdl/ramp_table.sv
hdl/step_tick_div.sv
hdl/wb_motor_regs.sv
hdl/step_motor_core.sv
hdl/stepper_top.sv
tb/stepper_clkgen.sv
tb/stepper_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module stepper_tb \
	-f stepper.f \
	-o stepper_sim

./obj_dir/stepper_sim > sim.log
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
